/* source/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath and address width
`define CPU_WORD_WIDTH 32

// Register file geometry
`define CPU_REG_INDEX_WIDTH 5
`define CPU_REG_COUNT 32

// Fetch
`define CPU_RESET_PC 32'h0000_0000
`define CPU_PC_STEP 4

`endif

/* source/CpuPkg.sv */
`include "cpu_macros.svh"

package CpuPkg;

    typedef logic [`CPU_WORD_WIDTH-1:0] Word;
    typedef logic [`CPU_REG_INDEX_WIDTH-1:0] RegIndex;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OpSpecial = 6'h00,
        OpJ = 6'h02,
        OpBeq = 6'h04,
        OpBne = 6'h05,
        OpAddiu = 6'h09,
        OpLui = 6'h0f,
        OpLw = 6'h23,
        OpSw = 6'h2b
    } Opcode;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd = 6'h24,
        FnOr = 6'h25,
        FnXor = 6'h26,
        FnSlt = 6'h2a
    } Funct;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluLui
    } AluOp;

endpackage

/* source/FetchUnit.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module FetchUnit import CpuPkg::*; (
    input logic clk,
    input logic reset,
    input logic hold,
    input logic redirect,
    input Word redirectAddr,
    output Word instAddr,
    output logic instRead,
    input Word instRdata,
    input logic instValid,
    output Word instruction,
    output Word pc,
    output logic fetchValid
);

    Word pcReg;
    logic running;

    // Read strobe comes up once reset is released
    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            pcReg <= `CPU_RESET_PC;
        end else begin
            running <= 1'b1;
            if (fetchValid && !hold) begin
                pcReg <= redirect ? redirectAddr : pcReg + `CPU_PC_STEP;
            end
        end
    end

    assign instAddr = pcReg;
    assign instRead = running;
    assign instruction = instRdata;
    assign pc = pcReg;
    // No valid word means a bubble for decode
    assign fetchValid = instValid && running;

endmodule

/* source/InstructionDecoder.sv */
`timescale 1ns/1ps

module InstructionDecoder import CpuPkg::*; (
    input Word instruction,
    output AluOp aluOp,
    output logic useImmediate,
    output Word immediate,
    output RegIndex sourceA,
    output RegIndex sourceB,
    output logic needsA,
    output logic needsB,
    output RegIndex destination,
    output logic memLoad,
    output logic memStore,
    output logic isBeq,
    output logic isBne,
    output logic isJump,
    output logic [25:0] jumpIndex
);

    Opcode opcode;
    Funct funct;
    RegIndex rd;

    assign opcode = Opcode'(instruction[31:26]);
    assign funct = Funct'(instruction[5:0]);
    assign rd = instruction[15:11];

    assign sourceA = instruction[25:21];
    assign sourceB = instruction[20:16];
    assign immediate = Word'($signed(instruction[15:0]));
    assign jumpIndex = instruction[25:0];

    always_comb begin
        aluOp = AluAdd;
        useImmediate = 1'b0;
        needsA = 1'b0;
        needsB = 1'b0;
        destination = '0;
        memLoad = 1'b0;
        memStore = 1'b0;
        isBeq = 1'b0;
        isBne = 1'b0;
        isJump = 1'b0;
        case (opcode)
            OpSpecial: begin
                needsA = 1'b1;
                needsB = 1'b1;
                destination = rd;
                case (funct)
                    FnAddu: aluOp = AluAdd;
                    FnSubu: aluOp = AluSub;
                    FnAnd: aluOp = AluAnd;
                    FnOr: aluOp = AluOr;
                    FnXor: aluOp = AluXor;
                    FnSlt: aluOp = AluSlt;
                    default: begin
                        // Unknown function, acts as a no-op
                        needsA = 1'b0;
                        needsB = 1'b0;
                        destination = '0;
                    end
                endcase
            end
            OpAddiu: begin
                needsA = 1'b1;
                useImmediate = 1'b1;
                destination = sourceB;
            end
            OpLui: begin
                aluOp = AluLui;
                useImmediate = 1'b1;
                destination = sourceB;
            end
            OpLw: begin
                needsA = 1'b1;
                useImmediate = 1'b1;
                memLoad = 1'b1;
                destination = sourceB;
            end
            OpSw: begin
                needsA = 1'b1;
                needsB = 1'b1;
                useImmediate = 1'b1;
                memStore = 1'b1;
            end
            OpBeq: begin
                needsA = 1'b1;
                needsB = 1'b1;
                isBeq = 1'b1;
            end
            OpBne: begin
                needsA = 1'b1;
                needsB = 1'b1;
                isBne = 1'b1;
            end
            OpJ: isJump = 1'b1;
            default: ;
        endcase
    end

endmodule

/* source/RegisterFile.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module RegisterFile import CpuPkg::*; (
    input logic clk,
    input logic reset,
    input RegIndex readIndexA,
    input RegIndex readIndexB,
    output Word readDataA,
    output Word readDataB,
    input RegIndex writeIndex,
    input Word writeData
);

    Word regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeIndex != '0) begin
            regs[writeIndex] <= writeData;
        end
    end

    // r0 is hardwired
    assign readDataA = (readIndexA == '0) ? '0 : regs[readIndexA];
    assign readDataB = (readIndexB == '0) ? '0 : regs[readIndexB];

endmodule

/* source/ArithmeticLogicUnit.sv */
`timescale 1ns/1ps

module ArithmeticLogicUnit import CpuPkg::*; (
    input AluOp op,
    input Word a,
    input Word b,
    output Word result
);

    logic lessThan;

    // Signed compare for slt
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            AluAdd: begin
                result = a + b;
            end
            AluSub: begin
                result = a - b;
            end
            AluAnd: begin
                result = a & b;
            end
            AluOr: begin
                result = a | b;
            end
            AluXor: begin
                result = a ^ b;
            end
            AluSlt: begin
                result = Word'(lessThan);
            end
            AluLui: begin
                // Immediate lands in the upper half
                result = b << 16;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* source/Cpu.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module Cpu import CpuPkg::*; (
    input logic clk,
    input logic reset,
    output Word instAddr,
    output logic instRead,
    input Word instRdata,
    input logic instValid,
    output Word dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output Word dataWdata,
    input Word dataRdata,
    input logic dataValid,
    output Word wbPc,
    output logic [3:0] wbRfWen,
    output RegIndex wbRfWnum,
    output Word wbRfWdata
);

    logic memWait;
    logic decodeStall;
    logic redirect;
    Word redirectAddr;
    Word fetchInstruction;
    Word fetchPc;
    logic fetchValid;

    logic dValid;
    Word dInstruction;
    Word dPc;
    AluOp dAluOp;
    logic dUseImm;
    Word dImm;
    RegIndex dSourceA;
    RegIndex dSourceB;
    logic dNeedsA;
    logic dNeedsB;
    RegIndex dDest;
    logic dLoad;
    logic dStore;
    logic dIsBeq;
    logic dIsBne;
    logic dIsJump;
    logic [25:0] dJumpIndex;
    Word rfDataA;
    Word rfDataB;
    Word operandA;
    Word operandB;
    logic busyA;
    logic busyB;
    logic operandsEqual;
    logic branchTaken;
    logic isControl;

    logic eValid;
    Word ePc;
    AluOp eAluOp;
    logic eUseImm;
    Word eImm;
    Word eOpA;
    Word eOpB;
    RegIndex eDest;
    logic eLoad;
    logic eStore;
    Word aluResult;
    RegIndex eWriteIndex;

    logic mValid;
    Word mPc;
    Word mAluResult;
    Word mStoreData;
    RegIndex mDest;
    logic mLoad;
    logic mStore;
    RegIndex memForwardIndex;
    RegIndex memLoadIndex;

    logic wValid;
    Word wPc;
    Word wAluResult;
    Word wLoadData;
    logic wLoad;
    RegIndex wDest;
    RegIndex wWriteIndex;
    Word wWriteData;

    // Priority is memory, then writeback, then register file
    function automatic Word selectOperand(
        input RegIndex source,
        input Word regValue,
        input RegIndex memIndex,
        input Word memValue,
        input RegIndex wbIndex,
        input Word wbValue
    );
        Word value;
        if (source == '0) begin
            value = '0;
        end else if (source == memIndex) begin
            value = memValue;
        end else if (source == wbIndex) begin
            value = wbValue;
        end else begin
            value = regValue;
        end
        return value;
    endfunction

    // Value not ready yet for decode
    function automatic logic operandBusy(
        input logic needed,
        input RegIndex source,
        input RegIndex execIndex,
        input RegIndex loadIndex
    );
        return needed && source != '0 && (source == execIndex || source == loadIndex);
    endfunction

    FetchUnit fetch (
        .clk(clk),
        .reset(reset),
        .hold(memWait || decodeStall),
        .redirect(redirect),
        .redirectAddr(redirectAddr),
        .instAddr(instAddr),
        .instRead(instRead),
        .instRdata(instRdata),
        .instValid(instValid),
        .instruction(fetchInstruction),
        .pc(fetchPc),
        .fetchValid(fetchValid)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            dValid <= 1'b0;
        end else if (!memWait && !decodeStall) begin
            dValid <= fetchValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!memWait && !decodeStall) begin
            dInstruction <= fetchInstruction;
            dPc <= fetchPc;
        end
    end

    InstructionDecoder decoder (
        .instruction(dInstruction),
        .aluOp(dAluOp),
        .useImmediate(dUseImm),
        .immediate(dImm),
        .sourceA(dSourceA),
        .sourceB(dSourceB),
        .needsA(dNeedsA),
        .needsB(dNeedsB),
        .destination(dDest),
        .memLoad(dLoad),
        .memStore(dStore),
        .isBeq(dIsBeq),
        .isBne(dIsBne),
        .isJump(dIsJump),
        .jumpIndex(dJumpIndex)
    );

    RegisterFile regFile (
        .clk(clk),
        .reset(reset),
        .readIndexA(dSourceA),
        .readIndexB(dSourceB),
        .readDataA(rfDataA),
        .readDataB(rfDataB),
        .writeIndex(wWriteIndex),
        .writeData(wWriteData)
    );

    assign eWriteIndex = eValid ? eDest : '0;
    assign memForwardIndex = (mValid && !mLoad) ? mDest : '0;
    assign memLoadIndex = (mValid && mLoad) ? mDest : '0;

    assign operandA = selectOperand(dSourceA, rfDataA, memForwardIndex, mAluResult,
                                    wWriteIndex, wWriteData);
    assign operandB = selectOperand(dSourceB, rfDataB, memForwardIndex, mAluResult,
                                    wWriteIndex, wWriteData);
    assign busyA = operandBusy(dNeedsA, dSourceA, eWriteIndex, memLoadIndex);
    assign busyB = operandBusy(dNeedsB, dSourceB, eWriteIndex, memLoadIndex);

    // Branches resolve here, delay slot must already be fetched
    assign operandsEqual = operandA == operandB;
    assign branchTaken = (dIsBeq && operandsEqual) || (dIsBne && !operandsEqual) || dIsJump;
    assign isControl = dIsBeq || dIsBne || dIsJump;
    assign decodeStall = dValid && (busyA || busyB || (isControl && !fetchValid));
    assign redirect = dValid && branchTaken && !decodeStall && !memWait;
    assign redirectAddr = dIsJump ? {dPc[`CPU_WORD_WIDTH-1 -: 4], dJumpIndex, 2'b00}
                                  : dPc + `CPU_PC_STEP + (dImm << 2);

    always_ff @(posedge clk) begin
        if (reset) begin
            eValid <= 1'b0;
        end else if (!memWait) begin
            eValid <= dValid && !decodeStall;
        end
    end

    always_ff @(posedge clk) begin
        if (!memWait) begin
            ePc <= dPc;
            eAluOp <= dAluOp;
            eUseImm <= dUseImm;
            eImm <= dImm;
            eOpA <= operandA;
            eOpB <= operandB;
            eDest <= dDest;
            eLoad <= dLoad;
            eStore <= dStore;
        end
    end

    ArithmeticLogicUnit alu (
        .op(eAluOp),
        .a(eOpA),
        .b(eUseImm ? eImm : eOpB),
        .result(aluResult)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            mValid <= 1'b0;
        end else if (!memWait) begin
            mValid <= eValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!memWait) begin
            mPc <= ePc;
            mAluResult <= aluResult;
            mStoreData <= eOpB;
            mDest <= eDest;
            mLoad <= eLoad;
            mStore <= eStore;
        end
    end

    // Request held from the memory register until dataValid
    assign dataAddr = mAluResult;
    assign dataWdata = mStoreData;
    assign dataRead = mValid && mLoad;
    assign dataWrite = mValid && mStore;
    assign memWait = (dataRead || dataWrite) && !dataValid;

    always_ff @(posedge clk) begin
        if (reset) begin
            wValid <= 1'b0;
        end else begin
            wValid <= mValid && !memWait;
        end
    end

    always_ff @(posedge clk) begin
        wPc <= mPc;
        wAluResult <= mAluResult;
        wLoadData <= dataRdata;
        wLoad <= mLoad;
        wDest <= mDest;
    end

    assign wWriteIndex = wValid ? wDest : '0;
    assign wWriteData = wLoad ? wLoadData : wAluResult;

    assign wbPc = wPc;
    assign wbRfWen = {4{wWriteIndex != '0}};
    assign wbRfWnum = wWriteIndex;
    assign wbRfWdata = wWriteData;

endmodule

/* bench/cpu_chk.sv */
`timescale 1ns/1ps

module CpuChk import CpuPkg::*; (
    input logic clk,
    input logic reset,
    input logic instRead,
    input Word dataAddr,
    input logic dataRead,
    input logic dataWrite,
    input Word dataWdata,
    input logic dataValid,
    input logic [3:0] wbRfWen,
    input RegIndex wbRfWnum
);

    int failureCount = 0;

    // Fetch strobe stays up once the core runs
    instReadRunning: assert property (@(posedge clk)
        !reset |=> instRead)
        else begin
            failureCount++;
            $error("instRead low while the core is out of reset");
        end

    noBothStrobes: assert property (@(posedge clk) disable iff (reset)
        !(dataRead && dataWrite))
        else begin
            failureCount++;
            $error("dataRead and dataWrite high together");
        end

    // Waiting request keeps address and data
    requestStable: assert property (@(posedge clk) disable iff (reset)
        (dataRead || dataWrite) && !dataValid |=> $stable(dataAddr) && $stable(dataWdata))
        else begin
            failureCount++;
            $error("data request changed while waiting for dataValid");
        end

    noZeroWrite: assert property (@(posedge clk) disable iff (reset)
        wbRfWen != 4'b0000 |-> wbRfWnum != '0)
        else begin
            failureCount++;
            $error("wbRfWen raised for register 0");
        end

    quietAfterReset: assert property (@(posedge clk)
        $fell(reset) |=> !dataRead && !dataWrite && wbRfWen == 4'b0000)
        else begin
            failureCount++;
            $error("strobe high in the first cycle after reset");
        end

endmodule

bind Cpu CpuChk chk (.*);

/* bench/CpuTb.sv */
`timescale 1ns/1ps

module CpuTb import CpuPkg::*; ();

    localparam int memWords = 256;
    // Instruction counts of aluChain, loadStore, loadUse, controlFlow and instGaps
    localparam int totalInstructions = 12 + 10 + 4 + 13 + 12;
    localparam int cycleLimit = 8 * totalInstructions + 200;

    logic clk;
    logic reset;
    Word instAddr;
    logic instRead;
    Word instRdata;
    logic instValid;
    Word dataAddr;
    logic dataRead;
    logic dataWrite;
    Word dataWdata;
    Word dataRdata;
    logic dataValid;
    Word wbPc;
    logic [3:0] wbRfWen;
    RegIndex wbRfWnum;
    Word wbRfWdata;

    Word imem [memWords];
    Word dmem [memWords];
    int seed;
    logic instWait;
    logic dataWait;
    Word loadAddr;
    int errors;
    int checks;
    int cycleCount;

    Word tracePc [$];
    RegIndex traceNum [$];
    Word traceData [$];
    Word expPc [$];
    RegIndex expNum [$];
    Word expData [$];

    Cpu dut (
        .clk(clk),
        .reset(reset),
        .instAddr(instAddr),
        .instRead(instRead),
        .instRdata(instRdata),
        .instValid(instValid),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWdata(dataWdata),
        .dataRdata(dataRdata),
        .dataValid(dataValid),
        .wbPc(wbPc),
        .wbRfWen(wbRfWen),
        .wbRfWnum(wbRfWnum),
        .wbRfWdata(wbRfWdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Memories answer on the falling edge
    always @(negedge clk) begin
        instValid = instWait ? (($random(seed) & 3) != 0) : 1'b1;
        dataValid = dataWait ? (($random(seed) & 1) != 0) : 1'b1;
        instRdata = imem[instAddr[9:2]];
        dataRdata = dmem[dataAddr[9:2]];
        if (dataWrite && dataValid) begin
            dmem[dataAddr[9:2]] = dataWdata;
        end
    end

    // Writeback trace
    always @(negedge clk) begin
        if (!reset && wbRfWen != 4'b0000) begin
            if (wbRfWen != 4'b1111) begin
                errors++;
                $display("wbRfWen is only partly set at %0t", $time);
            end
            tracePc.push_back(wbPc);
            traceNum.push_back(wbRfWnum);
            traceData.push_back(wbRfWdata);
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            errors++;
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("checks %0d, errors %0d", checks, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic Word encodeR(Funct fn, RegIndex rd, RegIndex rs, RegIndex rt);
        return {OpSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic Word encodeI(Opcode op, RegIndex rt, RegIndex rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic Word encodeJ(Word target);
        return {OpJ, target[27:2]};
    endfunction

    function automatic Word fillWord(Word addr);
        return (addr * 32'h0001_0001) ^ 32'hc3a5_0000;
    endfunction

    task automatic checkWord(string testName, string what, Word expected, Word actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic checkIndex(string testName, string what, RegIndex expected,
                              RegIndex actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch in %s, %s: expected %0d, actual %0d",
                     testName, what, expected, actual);
        end
    endtask

    task automatic emit(Word inst);
        imem[loadAddr[9:2]] = inst;
        loadAddr += 4;
    endtask

    // Instruction with a register write expected at its own address
    task automatic emitWrite(Word inst, RegIndex dest, Word value);
        expPc.push_back(loadAddr);
        expNum.push_back(dest);
        expData.push_back(value);
        emit(inst);
    endtask

    task automatic holdReset();
        @(negedge clk);
        reset = 1'b1;
        instWait = 1'b0;
        dataWait = 1'b0;
        loadAddr = '0;
        for (int i = 0; i < memWords; i++) begin
            imem[i] = '0;
            dmem[i] = fillWord(Word'(i * 4));
        end
        tracePc.delete();
        traceNum.delete();
        traceData.delete();
        expPc.delete();
        expNum.delete();
        expData.delete();
    endtask

    task automatic releaseReset();
        repeat (5) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic compareTrace(string testName);
        while (traceNum.size() < expNum.size()) begin
            @(negedge clk);
        end
        // Drain so late or extra writes show up
        repeat (10) @(negedge clk);
        for (int i = 0; i < expNum.size(); i++) begin
            checkWord(testName, $sformatf("write %0d pc", i), expPc[i], tracePc[i]);
            checkIndex(testName, $sformatf("write %0d reg", i), expNum[i], traceNum[i]);
            checkWord(testName, $sformatf("write %0d data", i), expData[i], traceData[i]);
        end
        if (traceNum.size() > expNum.size()) begin
            errors++;
            $display("%s: %0d register writes seen where %0d were expected",
                     testName, traceNum.size(), expNum.size());
        end
    endtask

    task automatic runAluChain(string testName, logic gaps);
        Word r [12];
        holdReset();
        instWait = gaps;
        r[1] = 32'h0000_1234;
        r[2] = 32'h8000 << 16;
        r[3] = r[1] + r[2];
        r[4] = r[3] - r[1];
        r[5] = r[4] & r[3];
        r[6] = r[5] | r[1];
        r[7] = r[6] ^ r[3];
        r[8] = ($signed(r[2]) < $signed(r[1])) ? 32'd1 : 32'd0;
        r[9] = ($signed(r[1]) < $signed(r[2])) ? 32'd1 : 32'd0;
        r[10] = 32'hffff_ffff;
        r[11] = r[10];
        emitWrite(encodeI(OpAddiu, 1, 0, 16'h1234), 1, r[1]);
        emitWrite(encodeI(OpLui, 2, 0, 16'h8000), 2, r[2]);
        emitWrite(encodeR(FnAddu, 3, 1, 2), 3, r[3]);
        emitWrite(encodeR(FnSubu, 4, 3, 1), 4, r[4]);
        emitWrite(encodeR(FnAnd, 5, 4, 3), 5, r[5]);
        emitWrite(encodeR(FnOr, 6, 5, 1), 6, r[6]);
        emitWrite(encodeR(FnXor, 7, 6, 3), 7, r[7]);
        emitWrite(encodeR(FnSlt, 8, 2, 1), 8, r[8]);
        emitWrite(encodeR(FnSlt, 9, 1, 2), 9, r[9]);
        emitWrite(encodeI(OpAddiu, 10, 0, 16'hffff), 10, r[10]);
        // Write to r0 stays off the trace
        emit(encodeR(FnAddu, 0, 1, 1));
        emitWrite(encodeR(FnAddu, 11, 10, 0), 11, r[11]);
        releaseReset();
        compareTrace(testName);
    endtask

    task automatic runLoadStore();
        holdReset();
        dataWait = 1'b1;
        emitWrite(encodeI(OpAddiu, 1, 0, 16'h0100), 1, 32'h0000_0100);
        emitWrite(encodeI(OpAddiu, 2, 0, 16'h1111), 2, 32'h0000_1111);
        emitWrite(encodeI(OpLui, 3, 0, 16'habcd), 3, 32'habcd_0000);
        emitWrite(encodeI(OpAddiu, 4, 0, 16'hfff9), 4, 32'hffff_fff9);
        emit(encodeI(OpSw, 2, 1, 16'h0000));
        emit(encodeI(OpSw, 3, 1, 16'h0004));
        emit(encodeI(OpSw, 4, 1, 16'h0008));
        emitWrite(encodeI(OpLw, 5, 1, 16'h0000), 5, 32'h0000_1111);
        emitWrite(encodeI(OpLw, 6, 1, 16'h0004), 6, 32'habcd_0000);
        emitWrite(encodeI(OpLw, 7, 1, 16'h0008), 7, 32'hffff_fff9);
        releaseReset();
        compareTrace("loadStore");
        checkWord("loadStore", "mem 0x100", 32'h0000_1111, dmem[32'h100 >> 2]);
        checkWord("loadStore", "mem 0x104", 32'habcd_0000, dmem[32'h104 >> 2]);
        checkWord("loadStore", "mem 0x108", 32'hffff_fff9, dmem[32'h108 >> 2]);
        checkWord("loadStore", "mem 0x10c", fillWord(32'h10c), dmem[32'h10c >> 2]);
    endtask

    task automatic runLoadUse();
        holdReset();
        emitWrite(encodeI(OpAddiu, 1, 0, 16'h0040), 1, 32'h0000_0040);
        emitWrite(encodeI(OpAddiu, 2, 0, 16'h0025), 2, 32'h0000_0025);
        emitWrite(encodeI(OpLw, 3, 1, 16'h0000), 3, fillWord(32'h40));
        emitWrite(encodeR(FnAddu, 4, 3, 2), 4, fillWord(32'h40) + 32'h25);
        releaseReset();
        compareTrace("loadUse");
    endtask

    task automatic runControlFlow();
        holdReset();
        emitWrite(encodeI(OpAddiu, 1, 0, 16'd5), 1, 32'd5);
        emitWrite(encodeI(OpAddiu, 2, 0, 16'd5), 2, 32'd5);
        // Taken branch to 24
        emit(encodeI(OpBeq, 2, 1, 16'd3));
        emitWrite(encodeI(OpAddiu, 3, 0, 16'h0033), 3, 32'h33);
        emit(encodeI(OpAddiu, 4, 0, 16'h0044));
        emit(encodeI(OpAddiu, 4, 0, 16'h0045));
        emit(encodeI(OpBne, 2, 1, 16'd5));
        emitWrite(encodeI(OpAddiu, 5, 0, 16'h0055), 5, 32'h55);
        emitWrite(encodeI(OpAddiu, 6, 0, 16'h0066), 6, 32'h66);
        emit(encodeJ(32'd48));
        emitWrite(encodeI(OpAddiu, 7, 0, 16'h0077), 7, 32'h77);
        emit(encodeI(OpAddiu, 8, 0, 16'h0088));
        emitWrite(encodeI(OpAddiu, 9, 0, 16'h0099), 9, 32'h99);
        releaseReset();
        compareTrace("controlFlow");
    endtask

    initial begin
        seed = 32'h2bca_c4db;
        errors = 0;
        checks = 0;
        cycleCount = 0;
        reset = 1'b1;
        instRdata = '0;
        instValid = 1'b0;
        dataRdata = '0;
        dataValid = 1'b0;
        instWait = 1'b0;
        dataWait = 1'b0;
        loadAddr = '0;
        runAluChain("aluChain", 1'b0);
        runLoadStore();
        runLoadUse();
        runControlFlow();
        runAluChain("instGaps", 1'b1);
        // Port rule violations flagged by the bound checker
        errors += dut.chk.failureCount;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+source
source/CpuPkg.sv
source/FetchUnit.sv
source/InstructionDecoder.sv
source/RegisterFile.sv
source/ArithmeticLogicUnit.sv
source/Cpu.sv
bench/cpu_chk.sv
bench/CpuTb.sv
